//--- verilog/rsa_pkg.sv
// shared sizes and types for the 4x4 multiply engine
// all arithmetic wraps mod 2^16 and counters assume four steps and columns
package rsa_pkg;

  // array geometry
  localparam int ARRAY_X      = 4;
  localparam int ARRAY_Y      = 4;
  localparam int DATA_W       = 16;
  localparam int K_STEPS      = 4;
  // skewed wavefront needs x+y cycles to reach the far corner
  localparam int FLUSH_CYCLES = ARRAY_X + ARRAY_Y;
  localparam int STEP_W       = 2;
  localparam int FLUSH_W      = $clog2(FLUSH_CYCLES);

  typedef logic [DATA_W-1:0] data_t;
  // one A column, one result column or one bank word
  typedef data_t [ARRAY_X-1:0] a_vec_t;
  // one B row
  typedef data_t [ARRAY_Y-1:0] b_vec_t;

  typedef enum logic {A_STREAM, A_BANK} a_src_e;
  typedef enum logic [1:0] {B_STREAM, B_CONST, B_ZERO} b_src_e;

  typedef struct packed {
    a_src_e a_src;
    b_src_e b_src;
    logic   write_back;
  } rsa_cmd_t;

  // per-step control toward the operand selectors
  typedef struct packed {
    logic   en;
    a_src_e a_sel;
    b_src_e b_sel;
  } lane_ctrl_t;

endpackage

//--- verilog/rsa_pe.sv
// output-stationary MAC cell with 16-bit truncated products
// clear wins over drain and drain wins over calc
`timescale 1ns/100ps
module rsa_pe (
  input  logic           clk,
  input  logic           i_arst_n,
  input  logic           i_clear,
  input  logic           i_calc,
  input  rsa_pkg::data_t i_a,
  input  rsa_pkg::data_t i_b,
  input  logic           i_drain,
  input  rsa_pkg::data_t i_east_acc,
  output rsa_pkg::data_t o_a,
  output rsa_pkg::data_t o_b,
  output logic           o_calc,
  output rsa_pkg::data_t o_acc
);
  import rsa_pkg::*;

  data_t prod;

  // low half of the product only
  assign prod = DATA_W'(i_a * i_b);

  // operands move one cell per cycle
  always_ff @(posedge clk) begin
    o_a <= i_a;
    o_b <= i_b;
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_calc <= 1'b0;
      o_acc  <= '0;
    end else begin
      // calc bit rides east alongside A
      o_calc <= i_calc;
      if (i_clear) begin
        o_acc <= '0;
      end else if (i_drain) begin
        // shift results one cell toward column 0
        o_acc <= i_east_acc;
      end else if (i_calc) begin
        o_acc <= o_acc + prod;
      end
    end
  end

endmodule

//--- verilog/rsa_pe_array.sv
// A lanes and the calc bit are skewed by row and B lanes by column
// results leave through column 0 while the drain strobe is held
`timescale 1ns/100ps
module rsa_pe_array (
  input  logic            clk,
  input  logic            i_arst_n,
  input  logic            i_clear,
  input  logic            i_calc,
  input  rsa_pkg::a_vec_t i_a_col,
  input  rsa_pkg::b_vec_t i_b_row,
  input  logic            i_drain,
  output rsa_pkg::a_vec_t o_c_col
);
  import rsa_pkg::*;

  // grid nets with one spare slot past the far edge
  data_t a_h   [ARRAY_X][ARRAY_Y+1];
  logic  c_h   [ARRAY_X][ARRAY_Y+1];
  data_t b_v   [ARRAY_X+1][ARRAY_Y];
  data_t acc_h [ARRAY_X][ARRAY_Y+1];

  for (genvar i = 0; i < ARRAY_X; i++) begin : g_row
    if (i == 0) begin : g_edge
      assign a_h[i][0] = i_a_col[i];
      assign c_h[i][0] = i_calc;
    end else begin : g_skew
      // row i waits i cycles
      data_t a_dly [i];
      logic  c_dly [i];
      always_ff @(posedge clk) begin
        a_dly[0] <= i_a_col[i];
        for (int s = 1; s < i; s++) begin
          a_dly[s] <= a_dly[s-1];
        end
      end
      always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
          for (int s = 0; s < i; s++) begin
            c_dly[s] <= 1'b0;
          end
        end else begin
          c_dly[0] <= i_calc;
          for (int s = 1; s < i; s++) begin
            c_dly[s] <= c_dly[s-1];
          end
        end
      end
      assign a_h[i][0] = a_dly[i-1];
      assign c_h[i][0] = c_dly[i-1];
    end

    // nothing east of the last column
    assign acc_h[i][ARRAY_Y] = '0;
    assign o_c_col[i]        = acc_h[i][0];

    for (genvar j = 0; j < ARRAY_Y; j++) begin : g_col
      rsa_pe u_pe (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_clear    (i_clear),
        .i_calc     (c_h[i][j]),
        .i_a        (a_h[i][j]),
        .i_b        (b_v[i][j]),
        .i_drain    (i_drain),
        .i_east_acc (acc_h[i][j+1]),
        .o_a        (a_h[i][j+1]),
        .o_b        (b_v[i+1][j]),
        .o_calc     (c_h[i][j+1]),
        .o_acc      (acc_h[i][j])
      );
    end
  end

  for (genvar j = 0; j < ARRAY_Y; j++) begin : g_bcol
    if (j == 0) begin : g_edge
      assign b_v[0][j] = i_b_row[j];
    end else begin : g_skew
      // column j waits j cycles
      data_t b_dly [j];
      always_ff @(posedge clk) begin
        b_dly[0] <= i_b_row[j];
        for (int s = 1; s < j; s++) begin
          b_dly[s] <= b_dly[s-1];
        end
      end
      assign b_v[0][j] = b_dly[j-1];
    end
  end

endmodule

//--- verilog/rsa_operand_mux.sv
// one registered selector per lane with a single cycle of latency
// lanes load zero and calc drops whenever en is low
`timescale 1ns/100ps
module rsa_operand_mux (
  input  logic                clk,
  input  logic                i_arst_n,
  input  rsa_pkg::lane_ctrl_t i_lane,
  input  rsa_pkg::a_vec_t     i_a_stream,
  input  rsa_pkg::a_vec_t     i_a_bank,
  input  rsa_pkg::b_vec_t     i_b_stream,
  input  rsa_pkg::b_vec_t     i_b_const,
  output rsa_pkg::a_vec_t     o_a_col,
  output rsa_pkg::b_vec_t     o_b_row,
  output logic                o_calc
);
  import rsa_pkg::*;

  a_vec_t a_nxt;
  b_vec_t b_nxt;

  always_comb begin
    a_nxt = '0;
    b_nxt = '0;
    for (int i = 0; i < ARRAY_X; i++) begin
      // 2-way A side
      if (i_lane.en) begin
        a_nxt[i] = (i_lane.a_sel == A_BANK) ? i_a_bank[i] : i_a_stream[i];
      end
    end
    for (int j = 0; j < ARRAY_Y; j++) begin
      // B side, zero for B_ZERO and the unused code
      if (i_lane.en) begin
        case (i_lane.b_sel)
          B_STREAM: b_nxt[j] = i_b_stream[j];
          B_CONST:  b_nxt[j] = i_b_const[j];
          default:  b_nxt[j] = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    o_a_col <= a_nxt;
    o_b_row <= b_nxt;
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_calc <= 1'b0;
    end else begin
      o_calc <= i_lane.en;
    end
  end

endmodule

//--- verilog/rsa_const_buf.sv
// B words fill lanes 0..3 in strobe order and the address wraps mod 4
// a cycle without the strobe restarts the fill at lane 0
`timescale 1ns/100ps
module rsa_const_buf (
  input  logic            clk,
  input  logic            i_arst_n,
  input  logic            i_wr,
  input  rsa_pkg::data_t  i_data,
  output rsa_pkg::b_vec_t o_vec
);
  import rsa_pkg::*;

  logic [STEP_W-1:0] addr_q;
  b_vec_t            vec_q;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      addr_q <= '0;
      vec_q  <= '0;
    end else if (i_wr) begin
      vec_q[addr_q] <= i_data;
      addr_q        <= addr_q + 1'b1;
    end else begin
      // strobe gap
      addr_q <= '0;
    end
  end

  // held vector read with no delay
  assign o_vec = vec_q;

endmodule

//--- verilog/rsa_temp_bank.sv
// flop bank of K_STEPS result columns with one write port
// read is combinational so a new word is visible the cycle after its write
`timescale 1ns/100ps
module rsa_temp_bank (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_we,
  input  logic [rsa_pkg::STEP_W-1:0] i_waddr,
  input  rsa_pkg::a_vec_t            i_wdata,
  input  logic [rsa_pkg::STEP_W-1:0] i_raddr,
  output rsa_pkg::a_vec_t            o_rdata
);
  import rsa_pkg::*;

  // word k holds result column k
  a_vec_t mem_q [K_STEPS];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int w = 0; w < K_STEPS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (i_we) begin
      mem_q[i_waddr] <= i_wdata;
    end
  end

  // column k feeds A at step k of a chained product
  assign o_rdata = mem_q[i_raddr];

endmodule

//--- verilog/rsa_ctrl.sv
// one command at a time and start is ignored while busy
// drain lasts ARRAY_Y cycles with no way to stall it
`timescale 1ns/100ps
module rsa_ctrl (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_start,
  input  rsa_pkg::rsa_cmd_t          i_cmd,
  input  logic                       i_opnd_vld,
  output rsa_pkg::lane_ctrl_t        o_lane,
  output logic [rsa_pkg::STEP_W-1:0] o_step,
  output logic                       o_clear,
  output logic                       o_drain,
  output logic                       o_bank_we,
  output logic                       o_c_vld,
  output logic [rsa_pkg::STEP_W-1:0] o_c_idx,
  output logic                       o_busy,
  output logic                       o_done
);
  import rsa_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_FEED, S_FLUSH, S_DRAIN} state_e;

  state_e             state_q;
  rsa_cmd_t           cmd_q;
  logic [STEP_W-1:0]  step_q;
  logic [STEP_W-1:0]  col_q;
  logic [FLUSH_W-1:0] flush_q;
  logic               start_ok;
  logic               step_ok;
  logic               drain_act;

  assign start_ok  = i_start && (state_q == S_IDLE);
  // strobes outside feed are dropped
  assign step_ok   = i_opnd_vld && (state_q == S_FEED);
  assign drain_act = (state_q == S_DRAIN);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= S_IDLE;
      cmd_q   <= '0;
      step_q  <= '0;
      col_q   <= '0;
      flush_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_ok) begin
            cmd_q   <= i_cmd;
            step_q  <= '0;
            state_q <= S_FEED;
          end
        end
        S_FEED: begin
          if (step_ok) begin
            step_q <= step_q + 1'b1;
            if (step_q == STEP_W'(K_STEPS - 1)) begin
              flush_q <= '0;
              state_q <= S_FLUSH;
            end
          end
        end
        S_FLUSH: begin
          // let the last step reach PE(3,3)
          flush_q <= flush_q + 1'b1;
          if (flush_q == FLUSH_W'(FLUSH_CYCLES - 1)) begin
            col_q   <= '0;
            state_q <= S_DRAIN;
          end
        end
        default: begin
          col_q <= col_q + 1'b1;
          if (col_q == STEP_W'(ARRAY_Y - 1)) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  // lane control follows the latched command
  assign o_lane.en    = step_ok;
  assign o_lane.a_sel = cmd_q.a_src;
  assign o_lane.b_sel = cmd_q.b_src;
  assign o_step       = step_q;

  // accumulators clear on the accepted start
  assign o_clear   = start_ok;
  assign o_drain   = drain_act;
  assign o_c_vld   = drain_act;
  assign o_c_idx   = col_q;
  assign o_bank_we = drain_act && cmd_q.write_back;
  assign o_busy    = (state_q != S_IDLE);
  assign o_done    = drain_act && (col_q == STEP_W'(ARRAY_Y - 1));

endmodule

//--- verilog/rsa_top.sv
// 4x4 systolic C = A x B engine truncated to 16 bits
// inputs are sampled on the rising edge and results cannot be stalled
`timescale 1ns/100ps
module rsa_top (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_start,
  input  rsa_pkg::rsa_cmd_t          i_cmd,
  input  logic                       i_opnd_vld,
  input  rsa_pkg::a_vec_t            i_a_col,
  input  rsa_pkg::b_vec_t            i_b_row,
  input  logic                       i_const_vld,
  input  rsa_pkg::data_t             i_const_data,
  output logic                       o_busy,
  output logic                       o_c_vld,
  output rsa_pkg::a_vec_t            o_c_col,
  output logic [rsa_pkg::STEP_W-1:0] o_c_idx,
  output logic                       o_done
);
  import rsa_pkg::*;

  lane_ctrl_t        lane;
  logic [STEP_W-1:0] step;
  logic              clear;
  logic              drain;
  logic              bank_we;
  b_vec_t            const_vec;
  a_vec_t            bank_rdata;
  a_vec_t            mux_a;
  b_vec_t            mux_b;
  logic              mux_calc;

  rsa_ctrl u_ctrl (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_start    (i_start),
    .i_cmd      (i_cmd),
    .i_opnd_vld (i_opnd_vld),
    .o_lane     (lane),
    .o_step     (step),
    .o_clear    (clear),
    .o_drain    (drain),
    .o_bank_we  (bank_we),
    .o_c_vld    (o_c_vld),
    .o_c_idx    (o_c_idx),
    .o_busy     (o_busy),
    .o_done     (o_done)
  );

  rsa_operand_mux u_mux (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_lane     (lane),
    .i_a_stream (i_a_col),
    .i_a_bank   (bank_rdata),
    .i_b_stream (i_b_row),
    .i_b_const  (const_vec),
    .o_a_col    (mux_a),
    .o_b_row    (mux_b),
    .o_calc     (mux_calc)
  );

  rsa_const_buf u_const (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_wr     (i_const_vld),
    .i_data   (i_const_data),
    .o_vec    (const_vec)
  );

  // drained column k lands at bank word k
  rsa_temp_bank u_bank (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_we     (bank_we),
    .i_waddr  (o_c_idx),
    .i_wdata  (o_c_col),
    .i_raddr  (step),
    .o_rdata  (bank_rdata)
  );

  rsa_pe_array u_array (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_clear  (clear),
    .i_calc   (mux_calc),
    .i_a_col  (mux_a),
    .i_b_row  (mux_b),
    .i_drain  (drain),
    .o_c_col  (o_c_col)
  );

endmodule

//--- verif/rsa_checker.sv
// cycle model of the engine, compared with every DUT output on each rising edge
// expects start to busy in 1 cycle, FLUSH_CYCLES after the fourth step, then 4 drain cycles
`timescale 1ns/100ps
module rsa_checker (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_start,
  input  rsa_pkg::rsa_cmd_t          i_cmd,
  input  logic                       i_opnd_vld,
  input  rsa_pkg::a_vec_t            i_a_col,
  input  rsa_pkg::b_vec_t            i_b_row,
  input  logic                       i_const_vld,
  input  rsa_pkg::data_t             i_const_data,
  input  logic                       i_busy,
  input  logic                       i_c_vld,
  input  rsa_pkg::a_vec_t            i_c_col,
  input  logic [rsa_pkg::STEP_W-1:0] i_c_idx,
  input  logic                       i_done,
  output int                         o_err_cnt,
  output int                         o_done_cnt
);
  import rsa_pkg::*;

  typedef enum {M_IDLE, M_FEED, M_FLUSH, M_DRAIN} phase_e;

  phase_e   phase;
  int       cnt;
  rsa_cmd_t cmd;
  int       const_addr;
  b_vec_t   const_vec;
  a_vec_t   bank [K_STEPS];
  data_t    acc [ARRAY_X][ARRAY_Y];
  a_vec_t   a_op;
  b_vec_t   b_op;
  int       err_cnt = 0;
  int       done_cnt = 0;

  assign o_err_cnt  = err_cnt;
  assign o_done_cnt = done_cnt;

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] got);
    if (exp !== got) begin
      err_cnt++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  always @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      phase      = M_IDLE;
      cnt        = 0;
      cmd        = '0;
      const_addr = 0;
      const_vec  = '0;
      for (int w = 0; w < K_STEPS; w++) begin
        bank[w] = '0;
      end
      for (int i = 0; i < ARRAY_X; i++) begin
        for (int j = 0; j < ARRAY_Y; j++) begin
          acc[i][j] = '0;
        end
      end
    end else begin
      // outputs held over the cycle that just ended
      check_value("o_busy", phase != M_IDLE, i_busy);
      check_value("o_c_vld", phase == M_DRAIN, i_c_vld);
      check_value("o_done", phase == M_DRAIN && cnt == ARRAY_Y - 1, i_done);
      if (phase == M_DRAIN) begin
        check_value("o_c_idx", cnt, i_c_idx);
        for (int i = 0; i < ARRAY_X; i++) begin
          check_value($sformatf("o_c_col[%0d]", i), acc[i][cnt], i_c_col[i]);
        end
      end
      if (i_done) begin
        done_cnt++;
      end
      case (phase)
        M_IDLE: begin
          if (i_start) begin
            cmd = i_cmd;
            cnt = 0;
            for (int i = 0; i < ARRAY_X; i++) begin
              for (int j = 0; j < ARRAY_Y; j++) begin
                acc[i][j] = '0;
              end
            end
            phase = M_FEED;
          end
        end
        M_FEED: begin
          if (i_opnd_vld) begin
            // A column k from the stream or bank word k
            a_op = (cmd.a_src == A_BANK) ? bank[cnt] : i_a_col;
            case (cmd.b_src)
              B_STREAM: b_op = i_b_row;
              B_CONST:  b_op = const_vec;
              default:  b_op = '0;
            endcase
            for (int i = 0; i < ARRAY_X; i++) begin
              for (int j = 0; j < ARRAY_Y; j++) begin
                acc[i][j] = acc[i][j] + a_op[i] * b_op[j];
              end
            end
            if (cnt == K_STEPS - 1) begin
              phase = M_FLUSH;
              cnt   = 0;
            end else begin
              cnt++;
            end
          end
        end
        M_FLUSH: begin
          if (cnt == FLUSH_CYCLES - 1) begin
            phase = M_DRAIN;
            cnt   = 0;
          end else begin
            cnt++;
          end
        end
        default: begin
          // result column lands in bank word of the same index
          if (cmd.write_back) begin
            for (int i = 0; i < ARRAY_X; i++) begin
              bank[cnt][i] = acc[i][cnt];
            end
          end
          if (cnt == ARRAY_Y - 1) begin
            phase = M_IDLE;
          end
          cnt++;
        end
      endcase
      // buffer update comes after the step, which saw the old vector
      if (i_const_vld) begin
        const_vec[const_addr] = i_const_data;
        const_addr            = (const_addr + 1) % ARRAY_Y;
      end else begin
        const_addr = 0;
      end
    end
  end

endmodule

//--- verif/rsa_tb.sv
// random commands from seed 43789 against the 4x4 engine
// inputs change on the falling edge and a stuck DUT trips a wait timeout
`timescale 1ns/100ps
module rsa_tb;
  import rsa_pkg::*;

  logic              clk;
  logic              i_arst_n;
  logic              i_start;
  rsa_cmd_t          i_cmd;
  logic              i_opnd_vld;
  a_vec_t            i_a_col;
  b_vec_t            i_b_row;
  logic              i_const_vld;
  data_t             i_const_data;
  logic              o_busy;
  logic              o_c_vld;
  a_vec_t            o_c_col;
  logic [STEP_W-1:0] o_c_idx;
  logic              o_done;
  int                seed;
  int                timeout_cnt;
  int                other_cnt;
  int                cmd_cnt;
  int                err_cnt;
  int                done_cnt;

  rsa_top UUT (.*);

  rsa_checker u_checker (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_start      (i_start),
    .i_cmd        (i_cmd),
    .i_opnd_vld   (i_opnd_vld),
    .i_a_col      (i_a_col),
    .i_b_row      (i_b_row),
    .i_const_vld  (i_const_vld),
    .i_const_data (i_const_data),
    .i_busy       (o_busy),
    .i_c_vld      (o_c_vld),
    .i_c_col      (o_c_col),
    .i_c_idx      (o_c_idx),
    .i_done       (o_done),
    .o_err_cnt    (err_cnt),
    .o_done_cnt   (done_cnt)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  function automatic rsa_cmd_t make_cmd(input a_src_e a, input b_src_e b, input logic wb);
    rsa_cmd_t c;
    c.a_src      = a;
    c.b_src      = b;
    c.write_back = wb;
    return c;
  endfunction

  task automatic randomize_operands();
    for (int i = 0; i < ARRAY_X; i++) begin
      i_a_col[i] = 16'($random(seed));
    end
    for (int j = 0; j < ARRAY_Y; j++) begin
      i_b_row[j] = 16'($random(seed));
    end
  endtask

  // one burst of n strobes, then a gap cycle
  task automatic load_const(input int n);
    repeat (n) begin
      @(negedge clk);
      i_const_vld  = 1'b1;
      i_const_data = 16'($random(seed));
    end
    @(negedge clk);
    i_const_vld = 1'b0;
  endtask

  // strobes with no command open
  task automatic idle_strobes(input int n);
    repeat (n) begin
      @(negedge clk);
      i_opnd_vld = 1'b1;
      randomize_operands();
    end
    @(negedge clk);
    i_opnd_vld = 1'b0;
  endtask

  task automatic wait_for_done();
    int n;
    n = 0;
    while (!o_done && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (!o_done) begin
      $display("timeout at %0t: o_done never pulsed", $time);
      timeout_cnt++;
    end
  endtask

  task automatic wait_for_idle();
    int n;
    n = 0;
    while (o_busy && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (o_busy) begin
      $display("timeout at %0t: o_busy stayed high", $time);
      timeout_cnt++;
    end
  endtask

  task automatic run_cmd(input rsa_cmd_t cmd);
    int gap;
    @(negedge clk);
    i_cmd   = cmd;
    i_start = 1'b1;
    cmd_cnt++;
    @(negedge clk);
    i_start = 1'b0;
    for (int k = 0; k < K_STEPS; k++) begin
      gap = $random(seed) & 3;
      // idle cycles carry a stray start and a junk command
      repeat (gap) begin
        i_opnd_vld = 1'b0;
        i_start    = 1'b1;
        i_cmd      = 4'($random(seed));
        @(negedge clk);
      end
      i_start    = 1'b0;
      i_opnd_vld = 1'b1;
      randomize_operands();
      @(negedge clk);
    end
    // two extra strobes fall into the flush
    repeat (2) begin
      randomize_operands();
      @(negedge clk);
    end
    i_opnd_vld = 1'b0;
    wait_for_done();
    wait_for_idle();
  endtask

  task automatic run_random_cmds(input int n);
    a_src_e a;
    b_src_e b;
    logic   wb;
    repeat (n) begin
      a  = a_src_e'(1'($random(seed)));
      b  = b_src_e'(2'($unsigned($random(seed)) % 3));
      wb = 1'($random(seed));
      if ($random(seed) & 1) begin
        load_const(1 + ($unsigned($random(seed)) % 4));
      end
      run_cmd(make_cmd(a, b, wb));
    end
  endtask

  initial begin
    seed         = 43789;
    timeout_cnt  = 0;
    other_cnt    = 0;
    cmd_cnt      = 0;
    i_arst_n     = 1'b0;
    i_start      = 1'b0;
    i_cmd        = '0;
    i_opnd_vld   = 1'b0;
    i_a_col      = '0;
    i_b_row      = '0;
    i_const_vld  = 1'b0;
    i_const_data = '0;
    repeat (10) @(negedge clk);
    i_arst_n = 1'b1;
    idle_strobes(3);
    repeat (3) run_cmd(make_cmd(A_STREAM, B_STREAM, 1'b0));
    // full burst first
    load_const(4);
    run_cmd(make_cmd(A_STREAM, B_CONST, 1'b0));
    // short burst stops at lane 3 and the restart refills from lane 0
    load_const(3);
    load_const(2);
    run_cmd(make_cmd(A_STREAM, B_CONST, 1'b0));
    run_cmd(make_cmd(A_STREAM, B_ZERO, 1'b0));
    // chained products through the bank
    run_cmd(make_cmd(A_STREAM, B_STREAM, 1'b1));
    run_cmd(make_cmd(A_BANK, B_STREAM, 1'b1));
    run_cmd(make_cmd(A_BANK, B_CONST, 1'b0));
    idle_strobes(2);
    run_random_cmds(12);
    repeat (4) @(negedge clk);
    if (done_cnt != cmd_cnt) begin
      $display("wrong number of completions: %0d commands but %0d o_done pulses",
               cmd_cnt, done_cnt);
      other_cnt++;
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d other", err_cnt, timeout_cnt,
             other_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && other_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
verilog/rsa_pkg.sv
verilog/rsa_pe.sv
verilog/rsa_pe_array.sv
verilog/rsa_operand_mux.sv
verilog/rsa_const_buf.sv
verilog/rsa_temp_bank.sv
verilog/rsa_ctrl.sv
verilog/rsa_top.sv
verif/rsa_checker.sv
verif/rsa_tb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of rsa_tb, exits nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rsa_tb -f filelist.f \
  -Mdir obj_dir -o rsa_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/rsa_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
